// ==== src.f ====
hdl/guitar_pkg.sv
hdl/match_pkg.sv
hdl/note_selector.sv
hdl/fret_mapper.sv
hdl/match_output_stage.sv
hdl/buffer_serializer.sv
verification/buffer_serializer_sva.sv
verification/tb_buffer_serializer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_buffer_serializer
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/tb_buffer_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_buffer_serializer;

    import match_pkg::*;
    import guitar_pkg::*;

    localparam int NUM_NOTES   = 37;
    localparam int MAX_FRET    = 17;
    localparam int IDLE_N      = 4;      // idle cycles right after reset
    localparam int PRIO_N      = 300;
    localparam int DIST_N      = 300;
    localparam int GAP_N       = 150;
    localparam int MAX_GAP     = 3;      // longest idle run between triggers
    localparam int TEST_CYCLES = 3 + IDLE_N + NUM_NOTES + PRIO_N + DIST_N
                                 + GAP_N * (MAX_GAP + 1) + 2;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 10 + 500;

    // open-note slot of each string, lowest string first
    localparam int OPEN_SLOT [NUM_STRINGS] = '{0, 5, 10, 15, 19, 24};

    typedef logic [NUM_NOTES-1:0]       trigger_t;
    typedef song_time_t [NUM_NOTES-1:0] time_table_t;

    logic          clk;
    logic          rst_n;
    song_time_t    song_time;
    trigger_t      match_trigger;
    time_table_t   match_time;
    match_result_t match;

    logic [31:0]   rng_state;
    match_result_t expect_q [$];    // two-deep delay line of expected results

    buffer_serializer i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .song_time     (song_time),
        .match_trigger (match_trigger),
        .match_time    (match_time),
        .match         (match)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the test sequence in %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic time_table_t random_times();
        time_table_t t;
        for (int i = 0; i < NUM_NOTES; i++) begin
            t[i] = song_time_t'(next_rand());
        end
        return t;
    endfunction

    function automatic trigger_t random_trigger();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        return {a[NUM_NOTES-33:0], b};
    endfunction

    // reference model: highest slot wins, fret = slot - open slot of the string
    function automatic match_result_t expected_for(input trigger_t    trig,
                                                   input time_table_t times,
                                                   input song_time_t  song);
        match_result_t r;
        int            slot;
        int            fret;
        r    = '0;
        slot = -1;
        for (int i = 0; i < NUM_NOTES; i++) begin
            if (trig[i]) begin
                slot = i;
            end
        end
        if (slot >= 0) begin
            r.match_en  = 1'b1;
            r.fret_time = times[slot];
            if (song > times[slot]) begin
                r.match_dt = song - times[slot];
            end else begin
                r.match_dt = times[slot] - song;
            end
            for (int s = 0; s < NUM_STRINGS; s++) begin
                fret = slot - OPEN_SLOT[s];
                if (fret >= 0 && fret <= MAX_FRET) begin
                    r.chord.fret_en[s] = 1'b1;
                    r.chord.fret[s]    = fret_t'(fret);
                end
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic check_chord(input chord_t got, input chord_t exp);
        if (got.fret_en !== exp.fret_en) begin
            report_mismatch("match.chord.fret_en", 64'(got.fret_en), 64'(exp.fret_en));
        end
        for (int s = 0; s < NUM_STRINGS; s++) begin
            if (got.fret[s] !== exp.fret[s]) begin
                report_mismatch($sformatf("match.chord.fret[%0d]", s),
                                64'(got.fret[s]), 64'(exp.fret[s]));
            end
        end
    endtask

    task automatic check_result(input match_result_t got, input match_result_t exp);
        if (got.match_en !== exp.match_en) begin
            report_mismatch("match.match_en", 64'(got.match_en), 64'(exp.match_en));
        end
        if (got.match_dt !== exp.match_dt) begin
            report_mismatch("match.match_dt", 64'(got.match_dt), 64'(exp.match_dt));
        end
        if (got.fret_time !== exp.fret_time) begin
            report_mismatch("match.fret_time", 64'(got.fret_time), 64'(exp.fret_time));
        end
        check_chord(got.chord, exp.chord);
    endtask

    // check the result due now, then drive the next input set
    task automatic apply_cycle(input trigger_t trig, input time_table_t times,
                               input song_time_t song);
        match_result_t due;
        @(posedge clk);
        #1;
        due = expect_q.pop_front();
        check_result(match, due);
        match_trigger = trig;
        match_time    = times;
        song_time     = song;
        expect_q.push_back(expected_for(trig, times, song));
    endtask

    initial begin
        trigger_t      trig;
        time_table_t   times;
        match_result_t zero_result;
        int            slot;
        int            gap;
        logic [31:0]   r;
        rng_state     = 32'hcacd_df2d;
        zero_result   = '0;
        rst_n         = 1'b0;
        match_trigger = '0;
        match_time    = '0;
        song_time     = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_q.push_back(zero_result);    // pipeline still holds reset values
        expect_q.push_back(zero_result);

        // idle after reset
        repeat (IDLE_N) apply_cycle('0, random_times(), song_time_t'(next_rand()));

        // one slot per cycle, back to back
        for (int i = 0; i < NUM_NOTES; i++) begin
            trig    = '0;
            trig[i] = 1'b1;
            apply_cycle(trig, random_times(), song_time_t'(next_rand()));
        end

        // dense and sparse multi-bit patterns
        for (int n = 0; n < PRIO_N; n++) begin
            trig = random_trigger();
            if (n % 2 == 1) begin
                trig = trig & random_trigger();
            end
            apply_cycle(trig, random_times(), song_time_t'(next_rand()));
        end

        // song time close to the winner's time, or anywhere
        for (int n = 0; n < DIST_N; n++) begin
            slot  = int'(next_rand() % 32'(NUM_NOTES));
            trig  = random_trigger();
            times = random_times();
            for (int i = slot + 1; i < NUM_NOTES; i++) begin
                trig[i] = 1'b0;
            end
            trig[slot] = 1'b1;
            r = next_rand();
            if (r[31]) begin
                apply_cycle(trig, times, times[slot] + song_time_t'(r[5:0]) - song_time_t'(32));
            end else begin
                apply_cycle(trig, times, song_time_t'(r));
            end
        end

        // random idle runs between triggers
        for (int n = 0; n < GAP_N; n++) begin
            gap = int'(next_rand() % 32'(MAX_GAP + 1));
            repeat (gap) apply_cycle('0, random_times(), song_time_t'(next_rand()));
            trig = random_trigger();
            trig[int'(next_rand() % 32'(NUM_NOTES))] = 1'b1;
            apply_cycle(trig, random_times(), song_time_t'(next_rand()));
        end

        // flush the last two results
        repeat (2) apply_cycle('0, '0, '0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule : tb_buffer_serializer

`default_nettype wire

// ==== verification/buffer_serializer_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module buffer_serializer_sva #(
    parameter int MAX_FRET = 17
) (
    input wire                           clk,
    input wire                           rst_n,
    input wire match_pkg::match_result_t match
);

    import match_pkg::*;
    import guitar_pkg::*;

    logic [1:0] cycles_out_of_reset;    // saturates at 3

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles_out_of_reset <= '0;
        end else if (cycles_out_of_reset != 2'd3) begin
            cycles_out_of_reset <= cycles_out_of_reset + 2'd1;
        end
    end

    // pipeline still drains reset values
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (cycles_out_of_reset < 2'd2) |-> !match.match_en)
        else $error("match_en set within two cycles of reset");

    a_idle_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !match.match_en |-> (match == '0))
        else $error("idle result carries nonzero fields");

    for (genvar s = 0; s < NUM_STRINGS; s++) begin : g_fret
        a_fret_on_neck: assert property (@(posedge clk) disable iff (!rst_n)
            match.chord.fret_en[s] |-> (int'(match.chord.fret[s]) <= MAX_FRET))
            else $error("string %0d reports a fret above the neck", s);
    end

endmodule : buffer_serializer_sva

bind buffer_serializer buffer_serializer_sva #(
    .MAX_FRET (MAX_FRET)
) i_buffer_serializer_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .match (match)
);

`default_nettype wire

// ==== hdl/buffer_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module buffer_serializer #(
    parameter int NUM_NOTES = 37,
    parameter int MAX_FRET  = 17
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire  match_pkg::song_time_t                song_time,
    input  wire  [NUM_NOTES-1:0]                       match_trigger,
    input  wire  match_pkg::song_time_t [NUM_NOTES-1:0] match_time,
    output match_pkg::match_result_t                   match
);

    import match_pkg::*;

    note_pick_t pick;    // stage 1 result, one cycle after the triggers

    note_selector #(
        .NUM_NOTES (NUM_NOTES)
    ) i_note_selector (
        .clk           (clk),
        .rst_n         (rst_n),
        .song_time     (song_time),
        .match_trigger (match_trigger),
        .match_time    (match_time),
        .pick          (pick)
    );

    // second register, result two edges after the triggers
    match_output_stage #(
        .NUM_NOTES (NUM_NOTES),
        .MAX_FRET  (MAX_FRET)
    ) i_match_output_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .pick  (pick),
        .match (match)
    );

endmodule : buffer_serializer

`default_nettype wire

// ==== hdl/match_output_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module match_output_stage #(
    parameter int NUM_NOTES = 37,
    parameter int MAX_FRET  = 17
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire match_pkg::note_pick_t pick,
    output match_pkg::match_result_t   match
);

    import match_pkg::*;
    import guitar_pkg::*;

    chord_t        chord;         // frets of the picked slot
    song_time_t    dt;            // |song_time - note_time|
    match_result_t match_next;

    fret_mapper #(
        .NUM_NOTES (NUM_NOTES),
        .MAX_FRET  (MAX_FRET)
    ) i_fret_mapper (
        .note  (pick.note),
        .chord (chord)
    );

    // absolute distance, note may be early or late
    always_comb begin
        if (pick.song_time >= pick.note_time) begin
            dt = pick.song_time - pick.note_time;
        end else begin
            dt = pick.note_time - pick.song_time;
        end
    end

    always_comb begin
        match_next = '0;    // idle cycle gives all-zero result
        if (pick.valid) begin
            match_next.match_en  = 1'b1;
            match_next.match_dt  = dt;
            match_next.fret_time = pick.note_time;
            match_next.chord     = chord;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match <= '0;
        end else begin
            match <= match_next;
        end
    end

endmodule : match_output_stage

`default_nettype wire

// ==== hdl/fret_mapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module fret_mapper #(
    parameter int NUM_NOTES = 37,
    parameter int MAX_FRET  = 17
) (
    input  wire match_pkg::note_idx_t note,
    output guitar_pkg::chord_t        chord
);

    import guitar_pkg::*;

    logic in_range;    // slot exists in the note buffer

    assign in_range = (int'(note) < NUM_NOTES);

    // Each string covers a window of MAX_FRET+1 slots starting at its
    // open-note offset. Strings outside their window show fret 0.
    always_comb begin
        chord = '0;
        for (int s = 0; s < NUM_STRINGS; s++) begin
            int rel;
            rel = int'(note) - STRING_OFFSET[s];    // fret on string s
            if (in_range && rel >= 0 && rel <= MAX_FRET) begin
                chord.fret_en[s] = 1'b1;
                chord.fret[s]    = fret_t'(rel);
            end
        end
    end

endmodule : fret_mapper

`default_nettype wire

// ==== hdl/note_selector.sv ====
`timescale 1ns/10ps
`default_nettype none

module note_selector #(
    parameter int NUM_NOTES = 37
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire  match_pkg::song_time_t                song_time,
    input  wire  [NUM_NOTES-1:0]                       match_trigger,
    input  wire  match_pkg::song_time_t [NUM_NOTES-1:0] match_time,
    output match_pkg::note_pick_t                      pick
);

    import match_pkg::*;

    logic       hit;          // any trigger set this cycle
    note_idx_t  hit_idx;      // highest triggered slot
    note_pick_t pick_next;

    // priority scan, higher slots overwrite lower ones
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < NUM_NOTES; i++) begin
            if (match_trigger[i]) begin
                hit     = 1'b1;
                hit_idx = note_idx_t'(i);
            end
        end
    end

    // all fields stay zero on an idle cycle
    always_comb begin
        pick_next = '0;
        if (hit) begin
            pick_next.valid     = 1'b1;
            pick_next.note      = hit_idx;
            pick_next.note_time = match_time[hit_idx];   // time of the winning slot
            pick_next.song_time = song_time;             // sampled in the same cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pick <= '0;
        end else begin
            pick <= pick_next;
        end
    end

endmodule : note_selector

`default_nettype wire

// ==== hdl/match_pkg.sv ====
`default_nettype none

package match_pkg;

    localparam int TIME_W = 16;    // song clock width

    // song clock and note time stamps share one format
    typedef logic [TIME_W-1:0] song_time_t;

    // slot number, up to 64 slots
    typedef logic [5:0] note_idx_t;

    // stage 1 result
    typedef struct packed {
        logic       valid;        // some trigger was set
        note_idx_t  note;         // highest triggered slot
        song_time_t note_time;    // time stamp of that slot
        song_time_t song_time;    // song clock sampled with it
    } note_pick_t;

    // registered output of the serializer
    typedef struct packed {
        logic               match_en;     // a note was matched this cycle
        song_time_t         match_dt;     // distance to the song clock
        song_time_t         fret_time;    // note time stamp
        guitar_pkg::chord_t chord;        // strings and frets for the note
    } match_result_t;

endpackage : match_pkg

`default_nettype wire

// ==== hdl/guitar_pkg.sv ====
`default_nettype none

package guitar_pkg;

    localparam int NUM_STRINGS = 6;    // standard six-string neck
    localparam int FRET_W      = 5;    // enough for frets 0..31

    // slot number of each open string, lowest string first
    // a note on string s sits at fret (slot - offset)
    localparam int STRING_OFFSET [NUM_STRINGS] = '{0, 5, 10, 15, 19, 24};

    // one fret number
    typedef logic [FRET_W-1:0] fret_t;

    // frets of all strings, string 5 (highest) in the top bits
    typedef fret_t [NUM_STRINGS-1:0] string_frets_t;

    // one valid bit per string
    typedef logic [NUM_STRINGS-1:0] string_mask_t;

    // where a note can be played on the neck
    typedef struct packed {
        string_mask_t  fret_en;    // string can reach the note
        string_frets_t fret;       // fret per string, 0 when unreachable
    } chord_t;

endpackage : guitar_pkg

`default_nettype wire
